// File: spu_macros.svh
/*
 * Sound RAM subsystem widths and sizes.
 * Word address and data widths, the memory read latency,
 * and the depths of the host request queue and the voice sample buffer.
 */
`ifndef SPU_MACROS_SVH
`define SPU_MACROS_SVH

// --------------------
// memory geometry.
`define SPU_ADDR_W 18           // 256K words.
`define SPU_DATA_W 16           // one word is two bytes.

// fixed read latency from the grant edge to q valid.
`define SPU_RAM_LATENCY 4

// --------------------
// queue depths.
`define SPU_HOST_DEPTH 4        // also the number of credits the host starts with.
`define SPU_SAMPLE_DEPTH 8      // slots in the voice sample buffer.

// width of the voice block word count.
`define SPU_COUNT_W 10

`endif

// File: spu_pkg.sv
/*
 * Sound RAM subsystem types.
 * Host request layout, the client tag carried with every read,
 * and the sample word held in the voice buffer.
 */
`include "spu_macros.svh"

package spu_pkg;

	// --------------------
	// host transfer request.
	// byte_sel bit 0 enables the low byte, bit 1 the high byte.
	// a read ignores data and byte_sel.
	typedef struct packed {
		logic                    we;        // 1 = write, 0 = read.
		logic [`SPU_ADDR_W-1:0]  addr;      // word address.
		logic [`SPU_DATA_W-1:0]  data;      // write data.
		logic [1:0]              byte_sel;  // per-byte write enable.
	} spu_host_req_t;

	// --------------------
	// client tag.
	// travels down the response pipeline next to every read,
	// so the returning word reaches the client that asked for it.
	typedef enum logic {
		CLIENT_HOST  = 1'b0,  // host transfer port.
		CLIENT_VOICE = 1'b1   // voice fetch engine.
	} spu_client_e;

	// --------------------
	// sample word.
	// one slot of the voice sample buffer.
	// the fetch engine stores raw memory words, decoding happens further on.
	typedef logic [`SPU_DATA_W-1:0] spu_sample_t;

endpackage

// File: spu_ram_if.sv
/*
 * Arbiter to sample memory bus.
 * The arbiter drives one access per cycle, the memory returns q
 * a fixed four cycles after a read and holds it until the next one.
 */
`include "spu_macros.svh"

interface spu_ram_if;

	logic                    re;        // read strobe, never high with we.
	logic                    we;        // write strobe.
	logic [`SPU_ADDR_W-1:0]  addr;      // word address for either access.
	logic [`SPU_DATA_W-1:0]  wdata;     // write data.
	logic [1:0]              byte_sel;  // byte enables for a write.
	logic [`SPU_DATA_W-1:0]  q;         // read data, held between reads.

	// the arbiter side issues accesses and sees q.
	modport arbiter (
		output re, we, addr, wdata, byte_sel,
		input  q
	);

	// the memory side takes accesses and returns q.
	modport ram (
		input  re, we, addr, wdata, byte_sel,
		output q
	);

endinterface

// File: spu_ram.sv
/*
 * Sample memory, 256K x 16 bits.
 * Byte-select writes merge into the stored word.
 * Reads pass a registered address, a registered array read and three
 * data stages, so q is valid four cycles after the read and stays put
 * until another read reaches the end of the pipeline.
 */
`include "spu_macros.svh"

module spu_ram (
	input  logic   i_clk,
	spu_ram_if.ram bus
);

	localparam int WORDS  = 1 << `SPU_ADDR_W;
	localparam int HALF_W = `SPU_DATA_W / 2;

	logic [`SPU_DATA_W-1:0]     ram [WORDS];  // behavioural array.
	logic [`SPU_ADDR_W-1:0]     addr_reg;     // address of the last read.
	logic [`SPU_RAM_LATENCY-1:0] rd_v;        // read marker per stage.
	logic [`SPU_DATA_W-1:0]     ram_q;        // registered array output.
	logic [`SPU_DATA_W-1:0]     data1;
	logic [`SPU_DATA_W-1:0]     data2;
	logic [`SPU_DATA_W-1:0]     data3;

	// --------------------
	// write port.
	// only the enabled bytes change, the other byte keeps its old value.
	always_ff @(posedge i_clk)
	begin
		if (bus.we)
		begin
			if (bus.byte_sel[0])
				ram[bus.addr][HALF_W-1:0] <= bus.wdata[HALF_W-1:0];   // low byte.
			if (bus.byte_sel[1])
				ram[bus.addr][`SPU_DATA_W-1:HALF_W] <= bus.wdata[`SPU_DATA_W-1:HALF_W];
		end
	end

	// --------------------
	// read pipeline.
	always_ff @(posedge i_clk)
	begin
		// the address is captured only by a read, a write leaves it alone.
		if (bus.re)
			addr_reg <= bus.addr;

		// the read marker walks alongside the word.
		rd_v <= {rd_v[`SPU_RAM_LATENCY-2:0], bus.re};

		// each stage moves only when it carries a live read.
		// idle cycles therefore leave the last word sitting at the output.
		if (rd_v[0])
			ram_q <= ram[addr_reg];   // array read one cycle after the address.
		if (rd_v[1])
			data1 <= ram_q;
		if (rd_v[2])
			data2 <= data1;
		if (rd_v[3])
			data3 <= data2;           // the final stage is valid after grant edge + 4.
	end

	assign bus.q = data3;

endmodule

// File: spu_credit_fifo.sv
/*
 * Credit-returning synchronous queue.
 * A circular buffer with read and write pointers and an occupancy count.
 * Every pop sends one credit pulse back to the producer on the next cycle,
 * so a producer that starts with DEPTH credits can never overfill it.
 */
module spu_credit_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 4
) (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_push,
	input  T     i_data,
	input  logic i_pop,
	output T     o_data,
	output logic o_valid,
	output logic o_credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T               mem [DEPTH];  // storage.
	logic [PTR_W-1:0] wr_ptr;     // next slot to fill.
	logic [PTR_W-1:0] rd_ptr;     // head of the queue.
	logic [CNT_W-1:0] count;      // entries held.
	logic           do_push;
	logic           do_pop;
	logic           full;

	assign full    = (count == CNT_W'(DEPTH));
	assign do_pop  = i_pop && o_valid;            // a pop on empty does nothing.
	assign do_push = i_push && (!full || do_pop); // room appears when the head leaves.

	// --------------------
	// payload storage.
	always_ff @(posedge i_clk)
	begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	// --------------------
	// pointers, count and credit return.
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			o_credit <= 1'b0;
		end
		else
		begin
			// pointers wrap at DEPTH, so any depth works.
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count    <= count + CNT_W'(do_push) - CNT_W'(do_pop);
			o_credit <= do_pop;  // one credit back per entry taken.
		end
	end

	assign o_data  = mem[rd_ptr];   // head is visible while o_valid.
	assign o_valid = (count != '0);

	// the producer has to hold a credit for every push.
	a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_push && full && !i_pop))
		else $error("push into a full queue, producer ran without credit.");

	// the consumer pops only what it has seen.
	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
		i_pop |-> o_valid)
		else $error("pop from an empty queue.");

endmodule

// File: spu_ram_arbiter.sv
/*
 * Sound RAM arbiter.
 * Fixed priority, the voice engine wins every conflict since playback
 * is real-time. The winner drives the memory bus in the same cycle.
 * A four-stage tag pipeline follows each read and steers q back to the
 * client that issued it, with a valid pulse after grant edge + 4.
 */
`include "spu_macros.svh"

module spu_ram_arbiter (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_host_valid,
	input  spu_pkg::spu_host_req_t  i_host_req,
	input  logic                    i_voice_req,
	input  logic [`SPU_ADDR_W-1:0]  i_voice_addr,
	output logic                    o_host_pop,
	output logic                    o_voice_grant,
	output logic [`SPU_DATA_W-1:0]  o_host_rdata,
	output logic                    o_host_rvalid,
	output logic [`SPU_DATA_W-1:0]  o_voice_rdata,
	output logic                    o_voice_rvalid,
	spu_ram_if.arbiter              bus
);

	import spu_pkg::*;

	localparam int LAT = `SPU_RAM_LATENCY;

	logic              host_grant;
	logic [LAT-1:0]    rd_pend;        // read marker per stage.
	spu_client_e       rd_tag [LAT];   // owner of the read in each stage.

	// --------------------
	// grant.
	assign o_voice_grant = i_voice_req;                   // voice always first.
	assign host_grant    = i_host_valid && !i_voice_req;  // host takes idle slots.
	assign o_host_pop    = host_grant;                    // queue head leaves on grant.

	// --------------------
	// bus drive from the winner.
	// a host write is the only path to we, every other grant is a read.
	assign bus.re       = o_voice_grant || (host_grant && !i_host_req.we);
	assign bus.we       = host_grant && i_host_req.we;
	assign bus.addr     = o_voice_grant ? i_voice_addr : i_host_req.addr;
	assign bus.wdata    = i_host_req.data;
	assign bus.byte_sel = i_host_req.byte_sel;

	// --------------------
	// response tag pipeline.
	always_ff @(posedge i_clk)
	begin
		rd_tag[0] <= o_voice_grant ? CLIENT_VOICE : CLIENT_HOST;
		for (int i = 1; i < LAT; i++)
			rd_tag[i] <= rd_tag[i-1];  // the owner moves one stage per cycle.
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			rd_pend        <= '0;
			o_host_rvalid  <= 1'b0;
			o_voice_rvalid <= 1'b0;
		end
		else
		begin
			rd_pend <= {rd_pend[LAT-2:0], bus.re};
			// the last stage is consumed on the same edge that makes q valid.
			o_host_rvalid  <= rd_pend[LAT-1] && (rd_tag[LAT-1] == CLIENT_HOST);
			o_voice_rvalid <= rd_pend[LAT-1] && (rd_tag[LAT-1] == CLIENT_VOICE);
		end
	end

	// q is held by the memory, so both clients can watch it directly.
	assign o_host_rdata  = bus.q;
	assign o_voice_rdata = bus.q;

	// one client per cycle, and never a read and a write together.
	a_one_grant: assert property (@(posedge i_clk) disable iff (i_reset)
		$onehot0({o_voice_grant, o_host_pop}) && $onehot0({bus.re, bus.we}))
		else $error("more than one grant in a cycle.");

endmodule

// File: spu_voice_fetch.sv
/*
 * Voice fetch engine.
 * Streams a block of consecutive words into a sample buffer.
 * A read is requested only against a credit, which stands for a buffer
 * slot that is neither filled nor reserved by a read still in flight.
 */
`include "spu_macros.svh"

module spu_voice_fetch (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_start,
	input  logic [`SPU_ADDR_W-1:0]  i_start_addr,
	input  logic [`SPU_COUNT_W-1:0] i_count,
	input  logic                    i_grant,
	input  logic [`SPU_DATA_W-1:0]  i_rdata,
	input  logic                    i_rvalid,
	input  logic                    i_sample_pop,
	output logic                    o_req,
	output logic [`SPU_ADDR_W-1:0]  o_addr,
	output logic                    o_busy,
	output logic                    o_sample_valid,
	output spu_pkg::spu_sample_t    o_sample_data
);

	import spu_pkg::*;

	localparam int CRED_W = $clog2(`SPU_SAMPLE_DEPTH + 1);

	logic [`SPU_COUNT_W-1:0] remaining;   // words still to request.
	logic [CRED_W-1:0]       credits;     // free, unreserved buffer slots.
	logic                    credit_ret;  // a slot was popped.

	// --------------------
	// block state.
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			remaining <= '0;
		end
		else if (!o_busy && i_start)
		begin
			// a new block loads only when the last one is fully issued.
			remaining <= i_count;
			o_addr    <= i_start_addr;
		end
		else if (i_grant)
		begin
			remaining <= remaining - 1'b1;
			o_addr    <= o_addr + 1'b1;     // consecutive words.
		end
	end

	assign o_busy = (remaining != '0);     // drops once the last read is granted.
	assign o_req  = o_busy && (credits != '0);

	// --------------------
	// credit counter.
	// a grant reserves a slot, a pop from the buffer frees one.
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			credits <= CRED_W'(`SPU_SAMPLE_DEPTH);
		else
			credits <= credits - CRED_W'(i_grant) + CRED_W'(credit_ret);
	end

	// --------------------
	// the sample buffer takes every returned word.
	spu_credit_fifo #(
		.T     (spu_sample_t),
		.DEPTH (`SPU_SAMPLE_DEPTH)
	) u_sample_buf (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_push   (i_rvalid),
		.i_data   (i_rdata),
		.i_pop    (i_sample_pop),
		.o_data   (o_sample_data),
		.o_valid  (o_sample_valid),
		.o_credit (credit_ret)
	);

	// credits can never outnumber buffer slots.
	a_credit_max: assert property (@(posedge i_clk) disable iff (i_reset)
		credits <= CRED_W'(`SPU_SAMPLE_DEPTH))
		else $error("voice credit overflow.");

	// the arbiter grants only what was asked for.
	a_grant_req: assert property (@(posedge i_clk) disable iff (i_reset)
		i_grant |-> o_req)
		else $error("voice grant without a request.");

endmodule

// File: spu_sound_ram.sv
/*
 * Sound RAM subsystem top level.
 * Host request queue, voice fetch engine, arbiter and sample memory.
 */
`include "spu_macros.svh"

module spu_sound_ram (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_host_valid,
	input  logic                    i_host_we,
	input  logic [`SPU_ADDR_W-1:0]  i_host_addr,
	input  logic [`SPU_DATA_W-1:0]  i_host_wdata,
	input  logic [1:0]              i_host_byte_sel,
	input  logic                    i_voice_start,
	input  logic [`SPU_ADDR_W-1:0]  i_voice_addr,
	input  logic [`SPU_COUNT_W-1:0] i_voice_count,
	input  logic                    i_sample_pop,
	output logic                    o_host_credit,
	output logic [`SPU_DATA_W-1:0]  o_host_rdata,
	output logic                    o_host_rvalid,
	output logic                    o_voice_busy,
	output logic                    o_sample_valid,
	output logic [`SPU_DATA_W-1:0]  o_sample_data
);

	import spu_pkg::*;

	spu_host_req_t           host_in;     // request as sent by the host.
	spu_host_req_t           host_head;   // oldest queued request.
	logic                    host_ready;  // queue not empty.
	logic                    host_pop;
	logic                    voice_req;
	logic [`SPU_ADDR_W-1:0]  voice_addr;
	logic                    voice_grant;
	logic [`SPU_DATA_W-1:0]  voice_rdata;
	logic                    voice_rvalid;

	spu_ram_if ram_bus ();

	assign host_in = '{we: i_host_we, addr: i_host_addr, data: i_host_wdata,
		byte_sel: i_host_byte_sel};

	// --------------------
	// the host request queue returns a host credit on each pop.
	spu_credit_fifo #(
		.T     (spu_host_req_t),
		.DEPTH (`SPU_HOST_DEPTH)
	) u_host_fifo (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_push   (i_host_valid),
		.i_data   (host_in),
		.i_pop    (host_pop),
		.o_data   (host_head),
		.o_valid  (host_ready),
		.o_credit (o_host_credit)
	);

	spu_voice_fetch u_voice (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_start        (i_voice_start),
		.i_start_addr   (i_voice_addr),
		.i_count        (i_voice_count),
		.i_grant        (voice_grant),
		.i_rdata        (voice_rdata),
		.i_rvalid       (voice_rvalid),
		.i_sample_pop   (i_sample_pop),
		.o_req          (voice_req),
		.o_addr         (voice_addr),
		.o_busy         (o_voice_busy),
		.o_sample_valid (o_sample_valid),
		.o_sample_data  (o_sample_data)
	);

	spu_ram_arbiter u_arb (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_host_valid   (host_ready),
		.i_host_req     (host_head),
		.i_voice_req    (voice_req),
		.i_voice_addr   (voice_addr),
		.o_host_pop     (host_pop),
		.o_voice_grant  (voice_grant),
		.o_host_rdata   (o_host_rdata),
		.o_host_rvalid  (o_host_rvalid),
		.o_voice_rdata  (voice_rdata),
		.o_voice_rvalid (voice_rvalid),
		.bus            (ram_bus.arbiter)
	);

	spu_ram u_ram (
		.i_clk (i_clk),
		.bus   (ram_bus.ram)
	);

endmodule

// File: tb_spu_sound_ram.sv
/*
 * Self-checking testbench for the sound RAM subsystem.
 * Reads operations from spu_tests.txt, drives the host port and the voice
 * engine on the falling edge, and checks host reads and voice samples
 * against a shadow memory that applies the byte-select rule.
 */
`include "spu_macros.svh"

module tb_spu_sound_ram;

	logic                    i_clk;
	logic                    i_reset;
	logic                    i_host_valid;
	logic                    i_host_we;
	logic [`SPU_ADDR_W-1:0]  i_host_addr;
	logic [`SPU_DATA_W-1:0]  i_host_wdata;
	logic [1:0]              i_host_byte_sel;
	logic                    i_voice_start;
	logic [`SPU_ADDR_W-1:0]  i_voice_addr;
	logic [`SPU_COUNT_W-1:0] i_voice_count;
	logic                    i_sample_pop;
	logic                    o_host_credit;
	logic [`SPU_DATA_W-1:0]  o_host_rdata;
	logic                    o_host_rvalid;
	logic                    o_voice_busy;
	logic                    o_sample_valid;
	logic [`SPU_DATA_W-1:0]  o_sample_data;

	// the test table holds one entry per line of the data file.
	logic [127:0] tst_name [$];
	logic [7:0]   tst_op [$];
	logic [31:0]  tst_addr [$];
	logic [31:0]  tst_data [$];
	logic [31:0]  tst_bsel [$];
	logic [31:0]  tst_exp [$];

	logic [`SPU_DATA_W-1:0]  shadow [int];      // words written so far.
	logic [`SPU_DATA_W-1:0]  host_exp [$];      // host reads in issue order.
	logic [127:0]            host_name [$];
	logic [`SPU_ADDR_W-1:0]  host_addr [$];
	logic [`SPU_DATA_W-1:0]  voice_exp [$];     // voice words in address order.
	logic [127:0]            voice_name [$];

	int          credits = `SPU_HOST_DEPTH;     // host credits on hand.
	int          sends = 0;
	int          credit_pulses = 0;
	int          errors = 0;
	int          host_reads = 0;
	int          voice_words = 0;
	int          cycle_count = 0;
	int          limit = 0;
	logic        pop_mode = 1'b0;               // 1 pops the buffer at random.
	logic [15:0] lfsr = 16'd13;

	spu_sound_ram uut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// --------------------
	// taps of x^16 + x^14 + x^13 + x^11 + 1, one step per random bit.
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic fb;
		fb = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], fb};
	endfunction

	// fill data mixes every address bit into the word.
	function automatic logic [15:0] fill_word(input logic [`SPU_ADDR_W-1:0] a);
		return a[15:0] ^ a[17:2] ^ 16'h5a3c;
	endfunction

	// --------------------
	// outputs are stable at the falling edge until the next rising edge.
	task automatic tick();
		logic take;
		logic [15:0] want;
		logic [127:0] name;
		@(negedge i_clk);
		take = 1'b0;
		if (o_host_credit === 1'b1)
		begin
			credits++;              // the queue handed one request on.
			credit_pulses++;
			if (credits > `SPU_HOST_DEPTH)
			begin
				errors++;
				$display("host credit count rose above the queue depth.");
			end
		end
		if (o_host_rvalid === 1'b1)
		begin
			if (host_exp.size() == 0)
			begin
				errors++;
				$display("host read data arrived with no read outstanding.");
			end
			else
			begin
				want = host_exp.pop_front();
				name = host_name.pop_front();
				host_reads++;
				if (o_host_rdata !== want)
					$display("** Error %0s: addr %h expected %h actual %h", name,
						host_addr[0], want, o_host_rdata);
				if (o_host_rdata !== want)
					errors++;
				void'(host_addr.pop_front());
			end
		end
		if (pop_mode && o_sample_valid === 1'b1)
		begin
			lfsr = lfsr_step(lfsr);
			take = lfsr[0];         // about half the offered words are taken.
		end
		if (take)
		begin
			if (voice_exp.size() == 0)
			begin
				errors++;
				$display("sample buffer offered a word beyond the end of the block.");
			end
			else
			begin
				want = voice_exp.pop_front();
				name = voice_name.pop_front();
				voice_words++;
				if (o_sample_data !== want)
				begin
					errors++;
					$display("** Error %0s: expected %h actual %h", name, want, o_sample_data);
				end
			end
		end
		i_sample_pop = take;        // the word checked above leaves at the next edge.
	endtask

	// --------------------
	// host requests go out one per credit.
	task automatic send_host(input logic we, input logic [`SPU_ADDR_W-1:0] a,
		input logic [15:0] d, input logic [1:0] b);
		while (credits == 0)
			tick();
		i_host_valid    = 1'b1;
		i_host_we       = we;
		i_host_addr     = a;
		i_host_wdata    = d;
		i_host_byte_sel = b;
		credits--;
		sends++;
		tick();
		i_host_valid = 1'b0;
	endtask

	task automatic write_word(input logic [`SPU_ADDR_W-1:0] a, input logic [15:0] d,
		input logic [1:0] b);
		logic [15:0] old;
		old = shadow.exists(int'(a)) ? shadow[int'(a)] : 16'hxxxx;
		if (b[0])
			old[7:0] = d[7:0];      // low byte.
		if (b[1])
			old[15:8] = d[15:8];    // high byte.
		shadow[int'(a)] = old;
		send_host(1'b1, a, d, b);
	endtask

	task automatic read_word(input logic [127:0] name, input logic [`SPU_ADDR_W-1:0] a,
		input logic [15:0] e);
		if (!shadow.exists(int'(a)))
		begin
			errors++;
			$display("test %0s reads address %h that was never written.", name, a);
		end
		else if (shadow[int'(a)] !== e)
		begin
			errors++;
			$display("test %0s expects %h but the shadow memory holds %h.", name, e,
				shadow[int'(a)]);
		end
		host_exp.push_back(e);
		host_name.push_back(name);
		host_addr.push_back(a);
		send_host(1'b0, a, 16'h0000, 2'b00);
	endtask

	// --------------------
	// a voice block starts once queued writes have all reached the memory.
	task automatic start_voice(input logic [127:0] name, input logic [`SPU_ADDR_W-1:0] a,
		input int n);
		while (o_voice_busy !== 1'b0 || credits != `SPU_HOST_DEPTH)
			tick();
		for (int k = 0; k < n; k++)
		begin
			if (!shadow.exists(int'(a) + k))
			begin
				errors++;
				$display("test %0s streams address %h that was never written.", name,
					a + `SPU_ADDR_W'(k));
			end
			voice_exp.push_back(shadow[int'(a) + k]);
			voice_name.push_back(name);
		end
		i_voice_start = 1'b1;
		i_voice_addr  = a;
		i_voice_count = `SPU_COUNT_W'(n);
		tick();
		i_voice_start = 1'b0;
		// the start edge has loaded the block, and no read can have been granted yet.
		if (n > 0 && o_voice_busy !== 1'b1)
		begin
			errors++;
			$display("test %0s started a voice block but the engine did not go busy.", name);
		end
	endtask

	task automatic wait_idle();
		while (credits != `SPU_HOST_DEPTH || host_exp.size() != 0 || o_voice_busy !== 1'b0
			|| voice_exp.size() != 0)
			tick();
	endtask

	// --------------------
	// the data file skips comment lines that start with #.
	task automatic load_tests();
		int fd;
		int n;
		string line;
		logic [127:0] name;
		logic [7:0] op;
		logic [31:0] a, d, b, e;
		fd = $fopen("spu_tests.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open spu_tests.txt.");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, d, b, e);
			if (n != 6)
			begin
				errors++;
				$display("malformed test line %0s", line);
				continue;
			end
			tst_name.push_back(name);
			tst_op.push_back(op);
			tst_addr.push_back(a);
			tst_data.push_back(d);
			tst_bsel.push_back(b);
			tst_exp.push_back(e);
		end
		$fclose(fd);
	endtask

	task automatic run_line(input int i);
		logic [`SPU_ADDR_W-1:0] a;
		a = tst_addr[i][`SPU_ADDR_W-1:0];
		case (tst_op[i])
			"W": write_word(a, tst_data[i][15:0], tst_bsel[i][1:0]);
			"R": read_word(tst_name[i], a, tst_exp[i][15:0]);
			"F":
			begin
				for (int k = 0; k < int'(tst_data[i]); k++)
					write_word(a + `SPU_ADDR_W'(k), fill_word(a + `SPU_ADDR_W'(k)), 2'b11);
			end
			"V": start_voice(tst_name[i], a, int'(tst_data[i]));
			"M": pop_mode = tst_data[i][0];
			"I": repeat (int'(tst_data[i])) tick();
			"S": wait_idle();
			default:
			begin
				errors++;
				$display("test %0s has an unknown operation.", tst_name[i]);
			end
		endcase
	endtask

	// --------------------
	// main sequence.
	initial
	begin
		int lengths;
		i_reset         = 1'b1;
		i_host_valid    = 1'b0;
		i_host_we       = 1'b0;
		i_host_addr     = '0;
		i_host_wdata    = '0;
		i_host_byte_sel = '0;
		i_voice_start   = 1'b0;
		i_voice_addr    = '0;
		i_voice_count   = '0;
		i_sample_pop    = 1'b0;
		lengths         = 0;
		load_tests();
		foreach (tst_op[i])
			if (tst_op[i] == "F" || tst_op[i] == "V" || tst_op[i] == "I")
				lengths += int'(tst_data[i]);
		limit = tst_op.size() * 40 + lengths * 10;
		repeat (10) tick();
		i_reset = 1'b0;
		if (o_host_rvalid !== 1'b0 || o_host_credit !== 1'b0 || o_sample_valid !== 1'b0
			|| o_voice_busy !== 1'b0)
		begin
			errors++;
			$display("outputs are not all low after reset.");
		end
		foreach (tst_op[i])
			run_line(i);
		pop_mode = 1'b1;            // drain whatever is left.
		wait_idle();
		repeat (`SPU_RAM_LATENCY + 4) tick();
		if (o_sample_valid !== 1'b0)
		begin
			errors++;
			$display("sample buffer still holds words after every block was read.");
		end
		if (credit_pulses != sends)
		begin
			errors++;
			$display("credit pulses do not match the host requests sent.");
		end
		$display("host reads %0d, voice words %0d, credits %0d of %0d sends, errors %0d",
			host_reads, voice_words, credit_pulses, sends, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// the watchdog limit scales with the test length.
	initial
	begin
		wait (limit > 0);
		while (cycle_count <= limit)
		begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the DUT stopped making progress.", cycle_count);
		$display("Test failed");
		$finish;
	end

endmodule

// File: spu_tests.txt
# columns: name op addr data byte_sel expected, all but name and op in hex.
# ops: W write, R read, F fill data words, V voice block of data words, M pop mode, I idle, S sync.
wr_full     W 00100 1234 3 0000
rd_full     R 00100 0000 0 1234
wr_lo       W 00100 abcd 1 0000
rd_lo       R 00100 0000 0 12cd
wr_hi       W 00100 5e00 2 0000
rd_hi       R 00100 0000 0 5ecd
wr_b        W 00101 ffff 3 0000
wr_b_none   W 00101 0000 0 0000
rd_b        R 00101 0000 0 ffff
wr_top      W 3ffff 8001 3 0000
rd_top      R 3ffff 0000 0 8001
fill_a      F 01000 0010 0 0000
rd_fill_a   R 01000 0000 0 4e3c
mode_rand   M 00000 0001 0 0000
voice_a     V 01000 0010 0 0000
wr_during   W 00200 c0de 3 0000
rd_during   R 00200 0000 0 c0de
rd_during2  R 00101 0000 0 ffff
rd_during3  R 00100 0000 0 5ecd
sync_a      S 00000 0000 0 0000
fill_b      F 30000 0018 0 0000
rd_fill_b   R 30010 0000 0 9a28
mode_hold   M 00000 0000 0 0000
voice_b     V 30000 0018 0 0000
wr_stall    W 00300 7777 3 0000
rd_stall    R 00300 0000 0 7777
idle_hold   I 00000 0040 0 0000
rd_stall2   R 3ffff 0000 0 8001
mode_rand2  M 00000 0001 0 0000
voice_c     V 01004 0008 0 0000
wr_lo2      W 00100 0099 1 0000
rd_lo2      R 00100 0000 0 5e99
sync_end    S 00000 0000 0 0000

// File: all.f
+incdir+.
spu_pkg.sv
spu_ram_if.sv
spu_ram.sv
spu_credit_fifo.sv
spu_ram_arbiter.sv
spu_voice_fetch.sv
spu_sound_ram.sv
tb_spu_sound_ram.sv

// File: Makefile
TOP = tb_spu_sound_ram

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean
